/* list.f */
noc_pkg.sv
noc_flit_fifo.sv
noc_axi_slave_adapter.sv
noc_crossbar.sv
noc_axi_master_adapter.sv
noc_top.sv
tb_axi_target_model.sv
tb_noc_top.sv

/* noc_axi_master_adapter.sv */
`timescale 1ns/1ps

module noc_axi_master_adapter import noc_pkg::*; #(
  parameter noc_node_t NODE_ID    = NODE_TGT0,
  parameter int        FIFO_DEPTH = 4
)(
  input  logic      clk,
  input  logic      i_rst,
  // fabric side
  input  logic      i_flit_valid,
  output logic      o_flit_ready,
  input  noc_flit_t i_flit,
  output logic      o_flit_valid,
  input  logic      i_flit_ready,
  output noc_flit_t o_flit,
  // target side
  output logic      o_req_valid,
  input  logic      i_req_ready,
  output axi_req_t  o_req,
  input  logic      i_rsp_valid,
  output logic      o_rsp_ready,
  input  axi_rsp_t  i_rsp
);
  logic      rx_valid;
  noc_flit_t rx_flit;
  logic      node_push_ready;
  logic      node_valid;
  noc_node_t node_src;
  logic      tx_push_ready;
  noc_flit_t tx_flit;

  // ----------------------------------------------------------------------
  // request path from flit to target request
  // ----------------------------------------------------------------------
  noc_flit_fifo #(
    .DEPTH (FIFO_DEPTH),
    .T     (noc_flit_t)
  ) u_rx_fifo (
    .clk          (clk                            ),
    .i_rst        (i_rst                          ),
    .i_push_valid (i_flit_valid                   ),
    .o_push_ready (o_flit_ready                   ),
    .i_push_data  (i_flit                         ),
    .o_pop_valid  (rx_valid                       ),
    .i_pop_ready  (i_req_ready && node_push_ready ),
    .o_pop_data   (rx_flit                        )
  );

  assign o_req_valid = rx_valid && node_push_ready;  // hold back once every slot is in flight

  always_comb begin
    o_req.id    = rx_flit.id;
    o_req.write = rx_flit.write;
    o_req.addr  = rx_flit.addr;
    o_req.wdata = rx_flit.data;
    o_req.strb  = rx_flit.strb;
  end

  // the target answers in order, so a FIFO of sources is enough to route responses
  noc_flit_fifo #(
    .DEPTH (FIFO_DEPTH),
    .T     (noc_node_t)
  ) u_node_fifo (
    .clk          (clk                          ),
    .i_rst        (i_rst                        ),
    .i_push_valid (rx_valid && i_req_ready      ),
    .o_push_ready (node_push_ready              ),
    .i_push_data  (rx_flit.src                  ),
    .o_pop_valid  (node_valid                   ),
    .i_pop_ready  (i_rsp_valid && tx_push_ready ),
    .o_pop_data   (node_src                     )
  );

  // ----------------------------------------------------------------------
  // response path from target response to flit
  // ----------------------------------------------------------------------
  assign o_rsp_ready = tx_push_ready && node_valid;

  always_comb begin
    tx_flit.kind  = FLIT_RSP;
    tx_flit.src   = NODE_ID;
    tx_flit.dst   = node_src;
    tx_flit.id    = i_rsp.id;
    tx_flit.write = i_rsp.write;
    tx_flit.addr  = '0;
    tx_flit.data  = i_rsp.rdata;
    tx_flit.strb  = '0;
    tx_flit.resp  = i_rsp.resp;
  end

  noc_flit_fifo #(
    .DEPTH (FIFO_DEPTH),
    .T     (noc_flit_t)
  ) u_tx_fifo (
    .clk          (clk                        ),
    .i_rst        (i_rst                      ),
    .i_push_valid (i_rsp_valid && node_valid  ),
    .o_push_ready (tx_push_ready              ),
    .i_push_data  (tx_flit                    ),
    .o_pop_valid  (o_flit_valid               ),
    .i_pop_ready  (i_flit_ready               ),
    .o_pop_data   (o_flit                     )
  );
endmodule

/* noc_axi_slave_adapter.sv */
`timescale 1ns/1ps

module noc_axi_slave_adapter import noc_pkg::*; #(
  parameter noc_node_t NODE_ID    = NODE_INI0,
  parameter int        FIFO_DEPTH = 4
)(
  input  logic      clk,
  input  logic      i_rst,
  // initiator side
  input  logic      i_req_valid,
  output logic      o_req_ready,
  input  axi_req_t  i_req,
  output logic      o_rsp_valid,
  input  logic      i_rsp_ready,
  output axi_rsp_t  o_rsp,
  // fabric side
  output logic      o_flit_valid,
  input  logic      i_flit_ready,
  output noc_flit_t o_flit,
  input  logic      i_flit_valid,
  output logic      o_flit_ready,
  input  noc_flit_t i_flit
);
  logic      dec_err;
  logic      tx_push_ready;
  noc_flit_t tx_flit;
  logic      err_valid;
  axi_rsp_t  err_rsp;
  logic      rx_valid;
  noc_flit_t rx_flit;
  axi_rsp_t  rx_rsp;

  // ----------------------------------------------------------------------
  // request path
  // ----------------------------------------------------------------------
  assign dec_err     = i_req.addr[NOC_ADDR_W-1];  // regions 2 and 3 map to nothing
  assign o_req_ready = !err_valid && tx_push_ready;

  always_comb begin
    tx_flit.kind  = FLIT_REQ;
    tx_flit.src   = NODE_ID;
    tx_flit.dst   = NODE_TGT0 + noc_node_t'(i_req.addr[NOC_ADDR_W-2]);
    tx_flit.id    = i_req.id;
    tx_flit.write = i_req.write;
    tx_flit.addr  = i_req.addr;
    tx_flit.data  = i_req.wdata;
    tx_flit.strb  = i_req.strb;
    tx_flit.resp  = RESP_OKAY;
  end

  noc_flit_fifo #(
    .DEPTH (FIFO_DEPTH),
    .T     (noc_flit_t)
  ) u_tx_fifo (
    .clk          (clk                                      ),
    .i_rst        (i_rst                                    ),
    .i_push_valid (i_req_valid && !err_valid && !dec_err    ),
    .o_push_ready (tx_push_ready                            ),
    .i_push_data  (tx_flit                                  ),
    .o_pop_valid  (o_flit_valid                             ),
    .i_pop_ready  (i_flit_ready                             ),
    .o_pop_data   (o_flit                                   )
  );

  // decode errors are answered here and never reach the crossbar
  always_ff @(posedge clk) begin
    if (i_rst) begin
      err_valid <= 1'b0;
    end else if (i_req_valid && o_req_ready && dec_err) begin
      err_valid <= 1'b1;
    end else if (err_valid && !rx_valid && i_rsp_ready) begin
      err_valid <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (i_req_valid && o_req_ready && dec_err) begin
      err_rsp.id    <= i_req.id;
      err_rsp.write <= i_req.write;
      err_rsp.rdata <= '0;
      err_rsp.resp  <= RESP_DECERR;
    end
  end

  // ----------------------------------------------------------------------
  // response path
  // ----------------------------------------------------------------------
  noc_flit_fifo #(
    .DEPTH (FIFO_DEPTH),
    .T     (noc_flit_t)
  ) u_rx_fifo (
    .clk          (clk          ),
    .i_rst        (i_rst        ),
    .i_push_valid (i_flit_valid ),
    .o_push_ready (o_flit_ready ),
    .i_push_data  (i_flit       ),
    .o_pop_valid  (rx_valid     ),
    .i_pop_ready  (i_rsp_ready  ),
    .o_pop_data   (rx_flit      )
  );

  always_comb begin
    rx_rsp.id    = rx_flit.id;
    rx_rsp.write = rx_flit.write;
    rx_rsp.rdata = rx_flit.data;
    rx_rsp.resp  = rx_flit.resp;
  end

  assign o_rsp_valid = rx_valid || err_valid;
  assign o_rsp       = rx_valid ? rx_rsp : err_rsp;  // fabric traffic goes first
endmodule

/* noc_crossbar.sv */
`timescale 1ns/1ps

module noc_crossbar import noc_pkg::*; (
  input  logic      clk,
  input  logic      i_rst,
  input  logic      i_flit_valid [NOC_PORTS],
  output logic      o_flit_ready [NOC_PORTS],
  input  noc_flit_t i_flit       [NOC_PORTS],
  output logic      o_flit_valid [NOC_PORTS],
  input  logic      i_flit_ready [NOC_PORTS],
  output noc_flit_t o_flit       [NOC_PORTS]
);
  localparam int PTR_W = $clog2(NOC_PORTS);

  logic [NOC_PORTS-1:0] req      [NOC_PORTS];  // req[out][in]
  logic [NOC_PORTS-1:0] gnt_any;
  logic [PTR_W-1:0]     gnt_idx  [NOC_PORTS];
  logic [PTR_W-1:0]     rr_ptr   [NOC_PORTS];
  logic [NOC_PORTS-1:0] out_free;
  logic                 out_valid [NOC_PORTS];
  noc_flit_t            out_flit  [NOC_PORTS];

  // ----------------------------------------------------------------------
  // per-output round-robin arbitration
  // ----------------------------------------------------------------------
  always_comb begin
    logic [PTR_W-1:0] idx;

    idx = '0;
    for (int i = 0; i < NOC_PORTS; i++) begin
      o_flit_ready[i] = 1'b0;
    end
    for (int o = 0; o < NOC_PORTS; o++) begin
      out_free[o] = !out_valid[o] || i_flit_ready[o];  // empty or draining this cycle
      gnt_any[o]  = 1'b0;
      gnt_idx[o]  = '0;
      for (int i = 0; i < NOC_PORTS; i++) begin
        req[o][i] = i_flit_valid[i] && (i_flit[i].dst == noc_node_t'(o));
      end
      // search starts at the pointer so the last winner ends up last in line
      for (int k = 0; k < NOC_PORTS; k++) begin
        idx = PTR_W'((int'(rr_ptr[o]) + k) % NOC_PORTS);
        if (!gnt_any[o] && out_free[o] && req[o][idx]) begin
          gnt_any[o] = 1'b1;
          gnt_idx[o] = idx;
        end
      end
      if (gnt_any[o]) begin
        o_flit_ready[gnt_idx[o]] = 1'b1;  // each input heads to one output only
      end
    end
  end

  // ----------------------------------------------------------------------
  // output registers
  // ----------------------------------------------------------------------
  always_ff @(posedge clk) begin
    for (int o = 0; o < NOC_PORTS; o++) begin
      if (i_rst) begin
        out_valid[o] <= 1'b0;
        rr_ptr[o]    <= '0;
      end else if (out_free[o]) begin
        out_valid[o] <= gnt_any[o];
        if (gnt_any[o]) rr_ptr[o] <= PTR_W'((int'(gnt_idx[o]) + 1) % NOC_PORTS);
      end
    end
  end

  always_ff @(posedge clk) begin
    for (int o = 0; o < NOC_PORTS; o++) begin
      if (gnt_any[o]) out_flit[o] <= i_flit[gnt_idx[o]];
    end
  end

  always_comb begin
    for (int o = 0; o < NOC_PORTS; o++) begin
      o_flit_valid[o] = out_valid[o];
      o_flit[o]       = out_flit[o];
    end
  end
endmodule

/* noc_flit_fifo.sv */
`timescale 1ns/1ps

module noc_flit_fifo #(
  parameter int  DEPTH = 4,
  parameter type T     = logic
)(
  input  logic clk,
  input  logic i_rst,
  input  logic i_push_valid,
  output logic o_push_ready,
  input  T     i_push_data,
  output logic o_pop_valid,
  input  logic i_pop_ready,
  output T     o_pop_data
);
  localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int CNT_W = $clog2(DEPTH + 1);

  T                 mem [DEPTH];
  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic [CNT_W-1:0] count;
  logic             push;
  logic             pop;

  assign o_push_ready = (count != CNT_W'(DEPTH));
  assign o_pop_valid  = (count != '0);
  assign o_pop_data   = mem[rd_ptr];
  assign push         = i_push_valid && o_push_ready;
  assign pop          = o_pop_valid && i_pop_ready;

  function automatic logic [PTR_W-1:0] next_ptr(logic [PTR_W-1:0] ptr);
    return (ptr == PTR_W'(DEPTH - 1)) ? '0 : ptr + PTR_W'(1);
  endfunction

  always_ff @(posedge clk) begin
    if (i_rst) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (push) wr_ptr <= next_ptr(wr_ptr);
      if (pop)  rd_ptr <= next_ptr(rd_ptr);
      case ({push, pop})
        2'b10:   count <= count + CNT_W'(1);
        2'b01:   count <= count - CNT_W'(1);
        default: count <= count;  // both or neither leaves the fill level alone
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (push) mem[wr_ptr] <= i_push_data;
  end
endmodule

/* noc_pkg.sv */
package noc_pkg;

  // ----------------------------------------------------------------------
  // widths and fabric size
  // ----------------------------------------------------------------------
  localparam int NOC_ADDR_W = 32;
  localparam int NOC_DATA_W = 32;
  localparam int NOC_ID_W   = 4;
  localparam int NOC_PORTS  = 4;  // ports 0 and 1 are initiators, 2 and 3 are targets

  typedef logic [1:0] noc_node_t;

  localparam noc_node_t NODE_INI0 = 2'd0;
  localparam noc_node_t NODE_INI1 = 2'd1;
  localparam noc_node_t NODE_TGT0 = 2'd2;  // address region 0 lands here
  localparam noc_node_t NODE_TGT1 = 2'd3;

  typedef enum logic [1:0] {
    RESP_OKAY   = 2'd0,
    RESP_SLVERR = 2'd2,
    RESP_DECERR = 2'd3
  } noc_resp_e;

  // ----------------------------------------------------------------------
  // single-beat transaction channels
  // ----------------------------------------------------------------------
  typedef struct packed {
    logic [NOC_ID_W-1:0]     id;
    logic                    write;
    logic [NOC_ADDR_W-1:0]   addr;
    logic [NOC_DATA_W-1:0]   wdata;
    logic [NOC_DATA_W/8-1:0] strb;
  } axi_req_t;

  typedef struct packed {
    logic [NOC_ID_W-1:0]   id;
    logic                  write;
    logic [NOC_DATA_W-1:0] rdata;
    noc_resp_e             resp;
  } axi_rsp_t;

  // ----------------------------------------------------------------------
  // the fabric packet is always a single flit
  // ----------------------------------------------------------------------
  typedef enum logic {
    FLIT_REQ = 1'b0,
    FLIT_RSP = 1'b1
  } noc_flit_kind_e;

  typedef struct packed {
    noc_flit_kind_e          kind;
    noc_node_t               src;
    noc_node_t               dst;
    logic [NOC_ID_W-1:0]     id;
    logic                    write;
    logic [NOC_ADDR_W-1:0]   addr;
    logic [NOC_DATA_W-1:0]   data;  // write data on requests, read data on responses
    logic [NOC_DATA_W/8-1:0] strb;
    noc_resp_e               resp;
  } noc_flit_t;

endpackage

/* noc_top.sv */
`timescale 1ns/1ps

module noc_top import noc_pkg::*; #(
  parameter int FIFO_DEPTH = 4
)(
  input  logic     clk,
  input  logic     i_rst,
  // initiator ports
  input  logic     i_ini_req_valid [2],
  output logic     o_ini_req_ready [2],
  input  axi_req_t i_ini_req       [2],
  output logic     o_ini_rsp_valid [2],
  input  logic     i_ini_rsp_ready [2],
  output axi_rsp_t o_ini_rsp       [2],
  // target ports
  output logic     o_tgt_req_valid [2],
  input  logic     i_tgt_req_ready [2],
  output axi_req_t o_tgt_req       [2],
  input  logic     i_tgt_rsp_valid [2],
  output logic     o_tgt_rsp_ready [2],
  input  axi_rsp_t i_tgt_rsp       [2]
);
  logic      to_xbar_valid   [NOC_PORTS];
  logic      to_xbar_ready   [NOC_PORTS];
  noc_flit_t to_xbar_flit    [NOC_PORTS];
  logic      from_xbar_valid [NOC_PORTS];
  logic      from_xbar_ready [NOC_PORTS];
  noc_flit_t from_xbar_flit  [NOC_PORTS];

  for (genvar i = 0; i < 2; i++) begin : g_slave_adapter
    noc_axi_slave_adapter #(
      .NODE_ID    ((i == 0) ? NODE_INI0 : NODE_INI1),
      .FIFO_DEPTH (FIFO_DEPTH                      )
    ) u_adapter (
      .clk          (clk                ),
      .i_rst        (i_rst              ),
      .i_req_valid  (i_ini_req_valid[i] ),
      .o_req_ready  (o_ini_req_ready[i] ),
      .i_req        (i_ini_req[i]       ),
      .o_rsp_valid  (o_ini_rsp_valid[i] ),
      .i_rsp_ready  (i_ini_rsp_ready[i] ),
      .o_rsp        (o_ini_rsp[i]       ),
      .o_flit_valid (to_xbar_valid[i]   ),
      .i_flit_ready (to_xbar_ready[i]   ),
      .o_flit       (to_xbar_flit[i]    ),
      .i_flit_valid (from_xbar_valid[i] ),
      .o_flit_ready (from_xbar_ready[i] ),
      .i_flit       (from_xbar_flit[i]  )
    );
  end

  noc_crossbar u_crossbar (
    .clk          (clk              ),
    .i_rst        (i_rst            ),
    .i_flit_valid (to_xbar_valid    ),
    .o_flit_ready (to_xbar_ready    ),
    .i_flit       (to_xbar_flit     ),
    .o_flit_valid (from_xbar_valid  ),
    .i_flit_ready (from_xbar_ready  ),
    .o_flit       (from_xbar_flit   )
  );

  // targets sit on crossbar ports 2 and 3
  for (genvar i = 0; i < 2; i++) begin : g_master_adapter
    noc_axi_master_adapter #(
      .NODE_ID    ((i == 0) ? NODE_TGT0 : NODE_TGT1),
      .FIFO_DEPTH (FIFO_DEPTH                      )
    ) u_adapter (
      .clk          (clk                  ),
      .i_rst        (i_rst                ),
      .i_flit_valid (from_xbar_valid[2+i] ),
      .o_flit_ready (from_xbar_ready[2+i] ),
      .i_flit       (from_xbar_flit[2+i]  ),
      .o_flit_valid (to_xbar_valid[2+i]   ),
      .i_flit_ready (to_xbar_ready[2+i]   ),
      .o_flit       (to_xbar_flit[2+i]    ),
      .o_req_valid  (o_tgt_req_valid[i]   ),
      .i_req_ready  (i_tgt_req_ready[i]   ),
      .o_req        (o_tgt_req[i]         ),
      .i_rsp_valid  (i_tgt_rsp_valid[i]   ),
      .o_rsp_ready  (o_tgt_rsp_ready[i]   ),
      .i_rsp        (i_tgt_rsp[i]         )
    );
  end
endmodule

/* tb_axi_target_model.sv */
`timescale 1ns/1ps

module tb_axi_target_model import noc_pkg::*; #(
  parameter logic [31:0] SEED = 32'h6dbe_6401
)(
  input  logic     clk,
  input  logic     i_rst,
  input  logic     i_req_valid,
  output logic     o_req_ready,
  input  axi_req_t i_req,
  output logic     o_rsp_valid,
  input  logic     i_rsp_ready,
  output axi_rsp_t o_rsp,
  output int       o_access_count
);
  logic [31:0]           lcg_state;
  logic [NOC_DATA_W-1:0] mem [16];
  axi_rsp_t              pending [$];  // accepted requests waiting for their response
  axi_rsp_t              rsp;

  function automatic logic [31:0] lcg_next(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  initial begin
    o_req_ready    = 1'b0;
    o_rsp_valid    = 1'b0;
    o_rsp          = '0;
    o_access_count = 0;
  end

  always @(posedge clk) begin
    if (i_rst) begin
      lcg_state      <= SEED;
      o_req_ready    <= 1'b0;
      o_rsp_valid    <= 1'b0;
      o_access_count <= 0;
      pending.delete();
      foreach (mem[w]) mem[w] = '0;
    end else begin
      if (o_rsp_valid && i_rsp_ready) void'(pending.pop_front());
      if (i_req_valid && o_req_ready) begin
        rsp.id    = i_req.id;
        rsp.write = i_req.write;
        rsp.resp  = RESP_OKAY;
        rsp.rdata = i_req.write ? '0 : mem[i_req.addr[5:2]];
        for (int b = 0; b < NOC_DATA_W / 8; b++) begin
          if (i_req.write && i_req.strb[b]) mem[i_req.addr[5:2]][8*b +: 8] = i_req.wdata[8*b +: 8];
        end
        pending.push_back(rsp);
        o_access_count <= o_access_count + 1;
      end
      lcg_state   <= lcg_next(lcg_state);
      o_req_ready <= lcg_state[28] | lcg_state[29];  // ready about three cycles in four
      // an offered response stays put until it is taken
      if (!(o_rsp_valid && !i_rsp_ready)) begin
        o_rsp_valid <= (pending.size() > 0) && lcg_state[30];
        if (pending.size() > 0) o_rsp <= pending[0];
      end
    end
  end
endmodule

/* tb_noc_top.sv */
`timescale 1ns/1ps

module tb_noc_top import noc_pkg::*; ();
  localparam int TIMEOUT_CYCLES = 500;
  localparam int IDLE_CYCLES    = 16;

  logic                  clk;
  logic                  rst;
  logic                  ini_req_valid [2];
  logic                  ini_req_ready [2];
  axi_req_t              ini_req       [2];
  logic                  ini_rsp_valid [2];
  logic                  ini_rsp_ready [2];
  axi_rsp_t              ini_rsp       [2];
  logic                  tgt_req_valid [2];
  logic                  tgt_req_ready [2];
  axi_req_t              tgt_req       [2];
  logic                  tgt_rsp_valid [2];
  logic                  tgt_rsp_ready [2];
  axi_rsp_t              tgt_rsp       [2];
  int                    tgt_count     [2];
  int                    exp_count     [2];
  logic [NOC_DATA_W-1:0] ref_mem       [2][16];  // expected contents of both targets

  noc_top #(.FIFO_DEPTH(4)) UUT (
    .clk             (clk           ),
    .i_rst           (rst           ),
    .i_ini_req_valid (ini_req_valid ),
    .o_ini_req_ready (ini_req_ready ),
    .i_ini_req       (ini_req       ),
    .o_ini_rsp_valid (ini_rsp_valid ),
    .i_ini_rsp_ready (ini_rsp_ready ),
    .o_ini_rsp       (ini_rsp       ),
    .o_tgt_req_valid (tgt_req_valid ),
    .i_tgt_req_ready (tgt_req_ready ),
    .o_tgt_req       (tgt_req       ),
    .i_tgt_rsp_valid (tgt_rsp_valid ),
    .o_tgt_rsp_ready (tgt_rsp_ready ),
    .i_tgt_rsp       (tgt_rsp       )
  );

  for (genvar t = 0; t < 2; t++) begin : g_target
    tb_axi_target_model #(.SEED(32'h6dbe_6401 + t)) u_target (
      .clk            (clk              ),
      .i_rst          (rst              ),
      .i_req_valid    (tgt_req_valid[t] ),
      .o_req_ready    (tgt_req_ready[t] ),
      .i_req          (tgt_req[t]       ),
      .o_rsp_valid    (tgt_rsp_valid[t] ),
      .i_rsp_ready    (tgt_rsp_ready[t] ),
      .o_rsp          (tgt_rsp[t]       ),
      .o_access_count (tgt_count[t]     )
    );
  end

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  // ----------------------------------------------------------------------
  // helpers
  // ----------------------------------------------------------------------
  task automatic compare(input string name, input logic [63:0] exp, input logic [63:0] act);
    if (exp !== act) begin
      $display("Mismatch in %s: expected %0h, actual %0h", name, exp, act);
      $display("Verification failed");
      $fatal(1);
    end
  endtask

  task automatic report_timeout(input string what);
    $display("Timeout while waiting for %s", what);
    $display("Verification failed");
    $fatal(1);
  endtask

  function automatic axi_req_t make_req(input logic [3:0] id, input logic write,
                                        input logic [31:0] addr, input logic [31:0] data,
                                        input logic [3:0] strb);
    axi_req_t req;
    req.id    = id;
    req.write = write;
    req.addr  = addr;
    req.wdata = data;
    req.strb  = strb;
    return req;
  endfunction

  // predicts the response and updates the reference memory on the way
  function automatic axi_rsp_t predict(input axi_req_t req);
    axi_rsp_t exp;
    int       t;
    int       w;
    exp.id    = req.id;
    exp.write = req.write;
    exp.rdata = '0;
    exp.resp  = RESP_OKAY;
    t = int'(req.addr[30]);
    w = int'(req.addr[5:2]);
    if (req.addr[31]) begin
      exp.resp = RESP_DECERR;  // regions 2 and 3 have no target
    end else begin
      exp_count[t]++;
      if (req.write) begin
        for (int b = 0; b < 4; b++) begin
          if (req.strb[b]) ref_mem[t][w][8*b +: 8] = req.wdata[8*b +: 8];
        end
      end else begin
        exp.rdata = ref_mem[t][w];
      end
    end
    return exp;
  endfunction

  task automatic send_req(input int ini, input axi_req_t req);
    int cycles;
    cycles = 0;
    ini_req_valid[ini] = 1'b1;
    ini_req[ini]       = req;
    do begin
      @(posedge clk);
      cycles++;
      if (cycles > TIMEOUT_CYCLES) report_timeout("a request to be accepted");
    end while (!ini_req_ready[ini]);
    #1;
    ini_req_valid[ini] = 1'b0;
  endtask

  task automatic recv_rsp(input int ini, output axi_rsp_t rsp);
    int cycles;
    cycles = 0;
    ini_rsp_ready[ini] = 1'b1;
    do begin
      @(posedge clk);
      cycles++;
      if (cycles > TIMEOUT_CYCLES) report_timeout("a response at an initiator");
    end while (!ini_rsp_valid[ini]);
    rsp = ini_rsp[ini];
    #1;
    ini_rsp_ready[ini] = 1'b0;
  endtask

  task automatic transact(input string name, input int ini, input axi_req_t req);
    axi_rsp_t exp;
    axi_rsp_t act;
    exp = predict(req);
    send_req(ini, req);
    recv_rsp(ini, act);
    compare(name, exp, act);
  endtask

  // requests go out back to back and responses are matched by id, which is unique per batch
  task automatic run_batch(input string name, input int ini, input axi_req_t reqs[$]);
    axi_rsp_t exp  [16];
    logic     seen [16];
    axi_rsp_t act;
    foreach (seen[i]) seen[i] = 1'b0;
    foreach (reqs[i]) exp[reqs[i].id] = predict(reqs[i]);
    fork
      foreach (reqs[i]) send_req(ini, reqs[i]);
      for (int n = 0; n < reqs.size(); n++) begin
        recv_rsp(ini, act);
        compare({name, " second response for one id"}, 1'b0, seen[act.id]);
        seen[act.id] = 1'b1;
        compare(name, exp[act.id], act);
      end
    join
  endtask

  // once everything is answered no initiator response and no target request may show up
  task automatic check_idle(input string name);
    repeat (IDLE_CYCLES) begin
      @(posedge clk);
      for (int p = 0; p < 2; p++) begin
        compare({name, " stray initiator response"}, 1'b0, ini_rsp_valid[p]);
        compare({name, " stray target request"}, 1'b0, tgt_req_valid[p]);
      end
    end
    #1;
  endtask

  task automatic check_counts(input string name);
    compare({name, " target 0 accesses"}, exp_count[0], tgt_count[0]);
    compare({name, " target 1 accesses"}, exp_count[1], tgt_count[1]);
  endtask

  // ----------------------------------------------------------------------
  // directed tests
  // ----------------------------------------------------------------------
  task automatic test_basic();
    for (int p = 0; p < 2; p++) begin
      compare("reset initiator response valid", 1'b0, ini_rsp_valid[p]);
      compare("reset target request valid", 1'b0, tgt_req_valid[p]);
    end
    transact("basic write", 0, make_req(4'h3, 1'b1, 32'h0000_0010, 32'ha5a5_1234, 4'hf));
    transact("basic read", 0, make_req(4'h4, 1'b0, 32'h0000_0010, '0, 4'h0));
    check_counts("basic");
  endtask

  task automatic test_strobe();
    transact("strobe full write", 0, make_req(4'h1, 1'b1, 32'h4000_0008, 32'h1122_3344, 4'hf));
    transact("strobe partial write", 0, make_req(4'h2, 1'b1, 32'h4000_0008, 32'haabb_ccdd, 4'h5));
    transact("strobe read", 0, make_req(4'h5, 1'b0, 32'h4000_0008, '0, 4'h0));
    check_counts("strobe");
  endtask

  task automatic test_decode_error();
    transact("decode error write", 0, make_req(4'h7, 1'b1, 32'h8000_0000, 32'hdead_beef, 4'hf));
    transact("decode error read", 1, make_req(4'h9, 1'b0, 32'hc000_0004, '0, 4'h0));
    check_idle("decode error");
    check_counts("decode error");  // neither target may count an access
  endtask

  task automatic test_arbitration();
    axi_req_t q0 [$];
    axi_req_t q1 [$];
    axi_req_t rd [$];
    for (int i = 0; i < 4; i++) begin
      q0.push_back(make_req(4'(i), 1'b1, 32'(4 * i), 32'h1000_0000 + 32'(i), 4'hf));
      q1.push_back(make_req(4'(i), 1'b1, 32'(4 * i + 32), 32'h2000_0000 + 32'(i), 4'hf));
      rd.push_back(make_req(4'(i), 1'b0, 32'(4 * i), '0, 4'h0));
      rd.push_back(make_req(4'(i + 8), 1'b0, 32'(4 * i + 32), '0, 4'h0));
    end
    fork
      run_batch("arbitration write initiator 0", 0, q0);
      run_batch("arbitration write initiator 1", 1, q1);
    join
    run_batch("arbitration read back", 0, rd);
    check_counts("arbitration");
  endtask

  task automatic test_back_pressure();
    axi_req_t reqs [$];
    axi_rsp_t exp  [$];
    axi_rsp_t act;
    reqs.push_back(make_req(4'h1, 1'b1, 32'h0000_0020, 32'hcafe_0001, 4'hf));
    reqs.push_back(make_req(4'h2, 1'b0, 32'h0000_0020, '0, 4'h0));
    reqs.push_back(make_req(4'h3, 1'b1, 32'h0000_0024, 32'hcafe_0002, 4'h3));
    reqs.push_back(make_req(4'h4, 1'b0, 32'h0000_0024, '0, 4'h0));
    foreach (reqs[i]) begin
      exp.push_back(predict(reqs[i]));
      send_req(1, reqs[i]);
    end
    repeat (20) @(posedge clk);  // responses pile up behind a low ready
    #1;
    foreach (exp[i]) begin
      recv_rsp(1, act);
      compare("back pressure issue order", exp[i], act);
    end
    check_counts("back pressure");
  endtask

  task automatic test_mixed_regions();
    axi_req_t   reqs [$];
    logic [1:0] region;
    for (int i = 0; i < 6; i++) begin
      region = (i % 2 == 0) ? 2'd1 : ((i % 4 == 1) ? 2'd2 : 2'd3);
      reqs.push_back(make_req(4'(i + 5), (i % 3 == 0), {region, 30'(4 * i)},
                              32'h5a00_0000 + 32'(i), 4'hf));
    end
    run_batch("mixed regions", 0, reqs);
    check_idle("mixed regions");
    check_counts("mixed regions");
  endtask

  initial begin
    rst = 1'b1;
    for (int p = 0; p < 2; p++) begin
      ini_req_valid[p] = 1'b0;
      ini_req[p]       = '0;
      ini_rsp_ready[p] = 1'b0;
      exp_count[p]     = 0;
      for (int w = 0; w < 16; w++) ref_mem[p][w] = '0;
    end
    repeat (5) @(posedge clk);
    #1;
    rst = 1'b0;
    test_basic();
    test_strobe();
    test_decode_error();
    test_arbitration();
    test_back_pressure();
    test_mixed_regions();
    $display("Verification passed");
    $finish;
  end
endmodule
